/* common/graph_pkg.sv */
package graph_pkg;

    typedef logic [14:0] node_str_t;   // Three 5-bit letter codes, first letter in the low bits
    typedef logic [9:0]  node_idx_t;
    typedef logic [11:0] edge_addr_t;
    typedef logic [12:0] edge_cnt_t;   // One bit wider than the address so a full store fits
    typedef logic [47:0] path_cnt_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam int MAX_NODES = 1024;
    localparam int MAX_EDGES = 4096;

    localparam node_str_t START_NODE_STR = {5'd20, 5'd14, 5'd24};  // "you"
    localparam node_str_t END_NODE_STR   = {5'd19, 5'd20, 5'd14};  // "out"

    localparam logic [7:0] CHAR_A     = 8'h61;
    localparam logic [7:0] CHAR_COLON = 8'h3a;
    localparam logic [7:0] CHAR_SPACE = 8'h20;
    localparam logic [7:0] CHAR_NL    = 8'h0a;

    localparam apb_addr_t REG_CTRL     = 8'h00;
    localparam apb_addr_t REG_DATA     = 8'h04;
    localparam apb_addr_t REG_STATUS   = 8'h08;
    localparam apb_addr_t REG_NODES    = 8'h0c;
    localparam apb_addr_t REG_EDGES    = 8'h10;
    localparam apb_addr_t REG_PATHS_LO = 8'h14;
    localparam apb_addr_t REG_PATHS_HI = 8'h18;

    typedef enum logic [1:0] {
        LOADING,
        DRAINING,
        COUNTING,
        DONE
    } ctrl_state_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        RD_EDGE,
        RD_SRC,
        ACCUM,
        PASS_END
    } count_state_t;

endpackage

/* hdl/apb_ctrl.sv */
module apb_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  graph_pkg::apb_addr_t  paddr,
    input  graph_pkg::apb_data_t  pwdata,
    input  logic                  decoding_done_idx,
    input  graph_pkg::node_idx_t  node_idx_cnt,
    input  graph_pkg::edge_cnt_t  edge_cnt,
    input  logic                  start_end_nodes_valid,
    input  logic                  count_done,
    input  graph_pkg::path_cnt_t  path_total,
    output graph_pkg::apb_data_t  prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  char_valid,
    output logic [7:0]            char_data,
    output logic                  input_end,
    output logic                  count_start
);

    graph_pkg::ctrl_state_t state;
    logic access;
    logic wr_data;
    logic wr_ctrl;
    logic mapped;
    logic busy;

    assign access  = psel && penable;
    assign wr_data = access && pwrite && (paddr == graph_pkg::REG_DATA);
    assign wr_ctrl = access && pwrite && (paddr == graph_pkg::REG_CTRL) && pwdata[0];

    // Characters go straight to the decoder in the access cycle
    assign char_valid = wr_data && (state == graph_pkg::LOADING);
    assign char_data  = pwdata[7:0];
    assign input_end  = wr_ctrl && (state == graph_pkg::LOADING);

    assign busy    = (state == graph_pkg::DRAINING) || (state == graph_pkg::COUNTING);
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (wr_data && state != graph_pkg::LOADING));

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            graph_pkg::REG_CTRL,
            graph_pkg::REG_DATA:     prdata = '0;  // Write-only
            graph_pkg::REG_STATUS:   prdata = {29'd0, start_end_nodes_valid,
                                               state == graph_pkg::DONE, busy};
            graph_pkg::REG_NODES:    prdata = 32'(node_idx_cnt);
            graph_pkg::REG_EDGES:    prdata = 32'(edge_cnt);
            graph_pkg::REG_PATHS_LO: prdata = path_total[31:0];
            graph_pkg::REG_PATHS_HI: prdata = 32'(path_total[47:32]);
            default:                 mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= graph_pkg::LOADING;
            count_start <= 1'b0;
        end else begin
            count_start <= 1'b0;
            case (state)
                graph_pkg::LOADING: begin
                    if (input_end)
                        state <= graph_pkg::DRAINING;
                end
                graph_pkg::DRAINING: begin
                    // The mapper has flushed its last edge once this arrives
                    if (decoding_done_idx) begin
                        state       <= graph_pkg::COUNTING;
                        count_start <= 1'b1;
                    end
                end
                graph_pkg::COUNTING: begin
                    if (count_done)
                        state <= graph_pkg::DONE;
                end
                default: state <= graph_pkg::DONE;
            endcase
        end
    end

    // The counter only answers a start that left the draining phase
    count_done_while_counting: assert property (
        @(posedge clk) disable iff (rst)
        count_done |-> state == graph_pkg::COUNTING
    ) else $error("count_done arrived outside the counting phase");

endmodule

/* hdl/line_decoder.sv */
module line_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  char_valid,
    input  logic [7:0]            char_data,
    input  logic                  input_end,
    output logic                  decoding_done_str,
    output logic                  src_node_str_valid,
    output logic                  edge_str_valid,
    output graph_pkg::node_str_t  src_node_str,
    output graph_pkg::node_str_t  dst_node_str
);

    graph_pkg::node_str_t token;
    logic [2:0] letter_cnt;  // 4 marks an overlong token
    logic after_colon;
    logic is_letter;
    logic is_colon;
    logic is_sep;
    logic token_ok;

    assign is_letter = (char_data >= graph_pkg::CHAR_A) && (char_data < graph_pkg::CHAR_A + 8'd26);
    assign is_colon  = char_data == graph_pkg::CHAR_COLON;
    assign is_sep    = (char_data == graph_pkg::CHAR_SPACE) || (char_data == graph_pkg::CHAR_NL);
    assign token_ok  = letter_cnt == 3'd3;

    always_ff @(posedge clk) begin
        if (rst) begin
            letter_cnt         <= '0;
            after_colon        <= 1'b0;
            src_node_str_valid <= 1'b0;
            edge_str_valid     <= 1'b0;
            decoding_done_str  <= 1'b0;
        end else begin
            src_node_str_valid <= char_valid && is_colon && token_ok;
            edge_str_valid     <= char_valid && is_sep && after_colon && token_ok;
            decoding_done_str  <= input_end;
            if (char_valid) begin
                if (is_letter) begin
                    letter_cnt <= (letter_cnt < 3'd3) ? letter_cnt + 3'd1 : 3'd4;
                end else if (is_colon) begin
                    letter_cnt  <= '0;
                    after_colon <= token_ok;  // A bad source name drops the whole line
                end else if (is_sep) begin
                    letter_cnt <= '0;
                    if (char_data == graph_pkg::CHAR_NL)
                        after_colon <= 1'b0;
                end
            end
        end
    end

    // New letters enter at the top, so the first one ends up lowest
    always_ff @(posedge clk) begin
        if (char_valid && is_letter)
            token <= {5'(char_data - graph_pkg::CHAR_A), token[14:5]};
        if (char_valid && is_colon && token_ok)
            src_node_str <= token;
        if (char_valid && is_sep && after_colon && token_ok)
            dst_node_str <= token;
    end

endmodule

/* node_map/node_id_mapper.sv */
module node_id_mapper (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  decoding_done_str,
    input  logic                  src_node_str_valid,
    input  logic                  edge_str_valid,
    input  graph_pkg::node_str_t  src_node_str,
    input  graph_pkg::node_str_t  dst_node_str,
    output logic                  decoding_done_idx,
    output logic                  src_node_idx_valid,
    output logic                  edge_idx_valid,
    output graph_pkg::node_idx_t  src_node_idx,
    output graph_pkg::node_idx_t  dst_node_idx,
    output graph_pkg::node_idx_t  node_idx_cnt,
    output graph_pkg::node_idx_t  start_node_idx,
    output graph_pkg::node_idx_t  end_node_idx,
    output logic                  start_end_nodes_valid
);

    // Table is addressed by the low ten bits of the node string
    graph_pkg::node_idx_t idx_table [graph_pkg::MAX_NODES];
    logic [graph_pkg::MAX_NODES-1:0] assigned;

    logic prev_src_valid;
    logic prev_dst_valid;
    logic prev_done;
    graph_pkg::node_str_t prev_src_str;
    graph_pkg::node_str_t prev_dst_str;
    graph_pkg::node_str_t out_src_str;
    graph_pkg::node_str_t out_dst_str;
    graph_pkg::node_idx_t src_rd_idx;
    graph_pkg::node_idx_t dst_rd_idx;
    logic src_rd_hit;
    logic dst_rd_hit;
    graph_pkg::node_idx_t current_index;
    logic start_captured;
    logic end_captured;
    logic new_node;
    graph_pkg::node_str_t new_str;

    assign new_node = (prev_src_valid && !src_rd_hit) || (prev_dst_valid && !dst_rd_hit);
    assign new_str  = prev_src_valid ? prev_src_str : prev_dst_str;
    assign node_idx_cnt          = current_index;
    assign start_end_nodes_valid = start_captured && end_captured;

    // Stage one reads both ports, stage two assigns and writes back
    always_ff @(posedge clk) begin
        src_rd_idx   <= idx_table[src_node_str[9:0]];
        dst_rd_idx   <= idx_table[dst_node_str[9:0]];
        src_rd_hit   <= assigned[src_node_str[9:0]];
        dst_rd_hit   <= assigned[dst_node_str[9:0]];
        prev_src_str <= src_node_str;
        prev_dst_str <= dst_node_str;
        out_src_str  <= prev_src_str;
        out_dst_str  <= prev_dst_str;
        src_node_idx <= src_rd_hit ? src_rd_idx : current_index;
        dst_node_idx <= dst_rd_hit ? dst_rd_idx : current_index;
        if (new_node)
            idx_table[new_str[9:0]] <= current_index;
        if (src_node_idx_valid && out_src_str == graph_pkg::START_NODE_STR)
            start_node_idx <= src_node_idx;
        if (edge_idx_valid && out_dst_str == graph_pkg::END_NODE_STR)
            end_node_idx <= dst_node_idx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_src_valid     <= 1'b0;
            prev_dst_valid     <= 1'b0;
            prev_done          <= 1'b0;
            src_node_idx_valid <= 1'b0;
            edge_idx_valid     <= 1'b0;
            decoding_done_idx  <= 1'b0;
            current_index      <= '0;
            assigned           <= '0;
            start_captured     <= 1'b0;
            end_captured       <= 1'b0;
        end else begin
            prev_src_valid     <= src_node_str_valid;
            prev_dst_valid     <= edge_str_valid;
            prev_done          <= decoding_done_str;
            src_node_idx_valid <= prev_src_valid;
            edge_idx_valid     <= prev_dst_valid;
            decoding_done_idx  <= prev_done;
            if (new_node) begin
                assigned[new_str[9:0]] <= 1'b1;
                current_index          <= current_index + 1'b1;
            end
            if (src_node_idx_valid && out_src_str == graph_pkg::START_NODE_STR)
                start_captured <= 1'b1;
            if (edge_idx_valid && out_dst_str == graph_pkg::END_NODE_STR)
                end_captured <= 1'b1;
        end
    end

    // Only one table write per cycle is possible
    valid_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(src_node_str_valid && edge_str_valid)
    ) else $error("Source and edge string events in the same cycle");

endmodule

/* path_count/edge_store.sv */
module edge_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   edge_idx_valid,
    input  graph_pkg::node_idx_t   src_node_idx,
    input  graph_pkg::node_idx_t   dst_node_idx,
    input  graph_pkg::edge_addr_t  edge_rd_addr,
    output graph_pkg::node_idx_t   edge_rd_src,
    output graph_pkg::node_idx_t   edge_rd_dst,
    output graph_pkg::edge_cnt_t   edge_cnt
);

    graph_pkg::node_idx_t src_mem [graph_pkg::MAX_EDGES];
    graph_pkg::node_idx_t dst_mem [graph_pkg::MAX_EDGES];
    logic append;

    assign append = edge_idx_valid && (edge_cnt != graph_pkg::edge_cnt_t'(graph_pkg::MAX_EDGES));

    always_ff @(posedge clk) begin
        if (rst)
            edge_cnt <= '0;
        else if (append)
            edge_cnt <= edge_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (append) begin
            src_mem[graph_pkg::edge_addr_t'(edge_cnt)] <= src_node_idx;
            dst_mem[graph_pkg::edge_addr_t'(edge_cnt)] <= dst_node_idx;
        end
        edge_rd_src <= src_mem[edge_rd_addr];
        edge_rd_dst <= dst_mem[edge_rd_addr];
    end

    no_append_when_full: assert property (
        @(posedge clk) disable iff (rst)
        edge_idx_valid |-> edge_cnt != graph_pkg::edge_cnt_t'(graph_pkg::MAX_EDGES)
    ) else $error("Edge arrived with the edge store full");

endmodule

/* path_count/path_counter.sv */
module path_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   count_start,
    input  graph_pkg::node_idx_t   node_idx_cnt,
    input  graph_pkg::edge_cnt_t   edge_cnt,
    input  graph_pkg::node_idx_t   start_node_idx,
    input  graph_pkg::node_idx_t   end_node_idx,
    input  logic                   start_end_nodes_valid,
    input  graph_pkg::node_idx_t   edge_rd_src,
    input  graph_pkg::node_idx_t   edge_rd_dst,
    output graph_pkg::edge_addr_t  edge_rd_addr,
    output logic                   count_done,
    output graph_pkg::path_cnt_t   path_total
);

    // Two banks of walk counts, bank_a selects the one holding length k
    graph_pkg::path_cnt_t cnt_mem [2*graph_pkg::MAX_NODES];
    graph_pkg::count_state_t state;
    logic bank_a;
    logic init_pass;
    logic changed;
    graph_pkg::node_idx_t clr_idx;
    graph_pkg::node_idx_t pass_cnt;
    graph_pkg::node_idx_t dst_q;
    graph_pkg::path_cnt_t a_rd;
    graph_pkg::path_cnt_t b_rd;
    logic wr_en;
    logic [10:0] wr_addr;
    graph_pkg::path_cnt_t wr_data;

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = {!bank_a, clr_idx};
        wr_data = '0;
        if (state == graph_pkg::CLEAR) begin
            wr_en   = 1'b1;
            wr_data = graph_pkg::path_cnt_t'(init_pass && clr_idx == start_node_idx);
        end else if (state == graph_pkg::ACCUM) begin
            wr_en   = 1'b1;
            wr_addr = {!bank_a, dst_q};
            wr_data = b_rd + a_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            cnt_mem[wr_addr] <= wr_data;
        a_rd  <= cnt_mem[{bank_a, edge_rd_src}];
        b_rd  <= cnt_mem[{!bank_a, edge_rd_dst}];
        dst_q <= edge_rd_dst;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= graph_pkg::IDLE;
            count_done   <= 1'b0;
            path_total   <= '0;
            bank_a       <= 1'b0;
            init_pass    <= 1'b0;
            changed      <= 1'b0;
            clr_idx      <= '0;
            pass_cnt     <= '0;
            edge_rd_addr <= '0;
        end else begin
            count_done <= 1'b0;
            case (state)
                graph_pkg::IDLE: begin
                    if (count_start) begin
                        path_total <= '0;
                        if (start_end_nodes_valid) begin
                            state     <= graph_pkg::CLEAR;
                            init_pass <= 1'b1;
                            clr_idx   <= '0;
                            pass_cnt  <= '0;
                        end else begin
                            count_done <= 1'b1;
                        end
                    end
                end
                graph_pkg::CLEAR: begin
                    clr_idx <= clr_idx + 1'b1;
                    if (clr_idx == node_idx_cnt - 1'b1) begin
                        clr_idx      <= '0;
                        edge_rd_addr <= '0;
                        changed      <= 1'b0;
                        if (init_pass) begin
                            init_pass <= 1'b0;  // Seeded bank turns into A, then B gets cleared
                            bank_a    <= !bank_a;
                        end else if (edge_cnt == '0) begin
                            state <= graph_pkg::PASS_END;
                        end else begin
                            state <= graph_pkg::RD_EDGE;
                        end
                    end
                end
                graph_pkg::RD_EDGE: state <= graph_pkg::RD_SRC;
                graph_pkg::RD_SRC:  state <= graph_pkg::ACCUM;
                graph_pkg::ACCUM: begin
                    if (a_rd != '0)
                        changed <= 1'b1;
                    if (dst_q == end_node_idx)
                        path_total <= path_total + a_rd;  // Walks of length k+1 ending at out
                    edge_rd_addr <= edge_rd_addr + 1'b1;
                    if (graph_pkg::edge_cnt_t'(edge_rd_addr) + 1'b1 == edge_cnt)
                        state <= graph_pkg::PASS_END;
                    else
                        state <= graph_pkg::RD_EDGE;
                end
                graph_pkg::PASS_END: begin
                    if (!changed || pass_cnt == node_idx_cnt - 1'b1) begin
                        state      <= graph_pkg::IDLE;
                        count_done <= 1'b1;
                    end else begin
                        bank_a   <= !bank_a;
                        pass_cnt <= pass_cnt + 1'b1;
                        state    <= graph_pkg::CLEAR;
                    end
                end
                default: state <= graph_pkg::IDLE;
            endcase
        end
    end

endmodule

/* hdl/graph_top.sv */
module graph_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  graph_pkg::apb_addr_t  paddr,
    input  graph_pkg::apb_data_t  pwdata,
    output graph_pkg::apb_data_t  prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic char_valid;
    logic [7:0] char_data;
    logic input_end;
    logic count_start;
    logic count_done;
    logic decoding_done_str;
    logic decoding_done_idx;
    logic src_node_str_valid;
    logic edge_str_valid;
    graph_pkg::node_str_t src_node_str;
    graph_pkg::node_str_t dst_node_str;
    logic edge_idx_valid;
    graph_pkg::node_idx_t src_node_idx;
    graph_pkg::node_idx_t dst_node_idx;
    graph_pkg::node_idx_t node_idx_cnt;
    graph_pkg::node_idx_t start_node_idx;
    graph_pkg::node_idx_t end_node_idx;
    logic start_end_nodes_valid;
    graph_pkg::edge_addr_t edge_rd_addr;
    graph_pkg::node_idx_t edge_rd_src;
    graph_pkg::node_idx_t edge_rd_dst;
    graph_pkg::edge_cnt_t edge_cnt;
    graph_pkg::path_cnt_t path_total;

    apb_ctrl u_apb_ctrl (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .decoding_done_idx, .node_idx_cnt, .edge_cnt, .start_end_nodes_valid,
        .count_done, .path_total, .prdata, .pready, .pslverr,
        .char_valid, .char_data, .input_end, .count_start
    );

    line_decoder u_line_decoder (
        .clk, .rst, .char_valid, .char_data, .input_end,
        .decoding_done_str, .src_node_str_valid, .edge_str_valid,
        .src_node_str, .dst_node_str
    );

    // Source events only matter inside the mapper
    node_id_mapper u_node_id_mapper (
        .clk, .rst, .decoding_done_str, .src_node_str_valid, .edge_str_valid,
        .src_node_str, .dst_node_str, .decoding_done_idx,
        .src_node_idx_valid(), .edge_idx_valid, .src_node_idx, .dst_node_idx,
        .node_idx_cnt, .start_node_idx, .end_node_idx, .start_end_nodes_valid
    );

    edge_store u_edge_store (
        .clk, .rst, .edge_idx_valid, .src_node_idx, .dst_node_idx,
        .edge_rd_addr, .edge_rd_src, .edge_rd_dst, .edge_cnt
    );

    path_counter u_path_counter (
        .clk, .rst, .count_start, .node_idx_cnt, .edge_cnt, .start_node_idx,
        .end_node_idx, .start_end_nodes_valid, .edge_rd_src, .edge_rd_dst,
        .edge_rd_addr, .count_done, .path_total
    );

endmodule

/* verif/graph_checker.sv */
module graph_checker (
    input  logic                  clk,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  graph_pkg::apb_addr_t  paddr,
    input  graph_pkg::apb_data_t  prdata,
    input  logic                  pready,
    input  logic                  pslverr,
    input  logic                  exp_en,
    input  logic                  exp_err,
    input  graph_pkg::apb_data_t  exp_data,
    input  logic [127:0]          test_name,
    output int                    check_cnt,
    output int                    error_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int checks = 0;
    int errors = 0;

    assign check_cnt = checks;
    assign error_cnt = errors;

    // Sampled mid-cycle, away from the edge where the bus is driven
    always @(negedge clk) begin
        if (psel && penable) begin
            if (pready !== 1'b1) begin
                errors++;
                $display("Test %0s: the slave held pready low at address 0x%02h",
                         test_name, paddr);
            end
            if (exp_en)
                checks++;
            // Every access without an expected error must complete cleanly
            if (pslverr !== (exp_en && exp_err)) begin
                errors++;
                $display("Test %0s: access to address 0x%02h gave pslverr %b, it should be %b",
                         test_name, paddr, pslverr, exp_en && exp_err);
            end
            if (exp_en && !exp_err && !pwrite && prdata !== exp_data) begin
                errors++;
                $display("CHECK FAILED test %0s reg 0x%02h expected 0x%08h actual 0x%08h",
                         test_name, paddr, exp_data, prdata);
            end
        end
    end

endmodule

/* verif/graph_tb.sv */
module graph_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [127:0] name;
        string        text;
        int           nodes;
        int           edges;
        longint       paths;
        logic         seen;
    } test_t;

    logic clk = 1'b0;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    graph_pkg::apb_addr_t paddr;
    graph_pkg::apb_data_t pwdata;
    graph_pkg::apb_data_t prdata;
    logic pready;
    logic pslverr;

    // What the checker should see on the next access
    logic exp_en;
    logic exp_err;
    graph_pkg::apb_data_t exp_data;
    logic [127:0] cur_name;
    int check_cnt;
    int error_cnt;

    test_t tests[$];
    int watchdog_cycles;
    logic table_ready = 1'b0;

    always #50 clk = !clk;

    graph_top u_dut (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    graph_checker u_checker (
        .clk, .psel, .penable, .pwrite, .paddr, .prdata, .pready, .pslverr,
        .exp_en, .exp_err, .exp_data, .test_name(cur_name), .check_cnt, .error_cnt
    );

    task automatic add_test(input logic [127:0] name, input string text, input int nodes,
                            input int edges, input longint paths, input logic seen);
        test_t t;
        t.name  = name;
        t.text  = text;
        t.nodes = nodes;
        t.edges = edges;
        t.paths = paths;
        t.seen  = seen;
        tests.push_back(t);
    endtask

    task automatic build_table();
        add_test("diamond", "you: aaa bbb\naaa: out\nbbb: out\n", 4, 4, 2, 1'b1);
        add_test("chain", "you: aaa\naaa: bbb\nbbb: ccc\nccc: out\n", 5, 4, 1, 1'b1);
        add_test("no_out", "you: aaa bbb\naaa: ccc\n", 4, 3, 0, 1'b0);
        // Same names on several lines keep their first index
        add_test("repeat", "you: aaa\nyou: bbb\naaa: bbb\nbbb: out\naaa: out\n", 4, 5, 3, 1'b1);
        // ab and q are too short, X9 holds no letters and the zz line has no valid source
        add_test("malformed", "you: ab aaa X9 bbb\naaa: out\nbbb: out q\nzz: ccc\n",
                 4, 4, 2, 1'b1);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Setup cycle, access cycle, one idle cycle
    task automatic apb_access(input logic wr, input graph_pkg::apb_addr_t addr,
                              input graph_pkg::apb_data_t data,
                              output graph_pkg::apb_data_t rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expect_access(input logic wr, input graph_pkg::apb_addr_t addr,
                                 input graph_pkg::apb_data_t data, input logic err);
        graph_pkg::apb_data_t rd;
        exp_en   = 1'b1;
        exp_err  = err;
        exp_data = data;
        apb_access(wr, addr, wr ? data : '0, rd);
        exp_en  = 1'b0;
        exp_err = 1'b0;
    endtask

    task automatic wait_done();
        graph_pkg::apb_data_t status;
        status = '0;
        while (!status[1])
            apb_access(1'b0, graph_pkg::REG_STATUS, '0, status);
    endtask

    initial begin
        rst     <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        exp_en   = 1'b0;
        exp_err  = 1'b0;
        exp_data = '0;
        cur_name = '0;
        build_table();
        watchdog_cycles = 0;
        foreach (tests[i])
            watchdog_cycles += tests[i].text.len() * 2 + tests[i].nodes * tests[i].edges * 4;
        watchdog_cycles *= 4;
        table_ready = 1'b1;

        foreach (tests[i]) begin
            cur_name = tests[i].name;
            reset_dut();
            for (int c = 0; c < tests[i].text.len(); c++)
                expect_access(1'b1, graph_pkg::REG_DATA,
                              graph_pkg::apb_data_t'(tests[i].text[c]), 1'b0);
            expect_access(1'b1, graph_pkg::REG_CTRL, 32'd1, 1'b0);
            wait_done();
            expect_access(1'b0, graph_pkg::REG_STATUS, {29'd0, tests[i].seen, 2'b10}, 1'b0);
            expect_access(1'b0, graph_pkg::REG_NODES, tests[i].nodes, 1'b0);
            expect_access(1'b0, graph_pkg::REG_EDGES, tests[i].edges, 1'b0);
            expect_access(1'b0, graph_pkg::REG_PATHS_LO, tests[i].paths[31:0], 1'b0);
            expect_access(1'b0, graph_pkg::REG_PATHS_HI,
                          graph_pkg::apb_data_t'(tests[i].paths[47:32]), 1'b0);
            expect_access(1'b0, 8'h1c, '0, 1'b1);  // Unmapped
            expect_access(1'b1, graph_pkg::REG_DATA, 32'h61, 1'b1);  // Input already closed
        end

        @(posedge clk);
        $display("Run finished with %0d checks and %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT never reported done",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* filelist.f */
common/graph_pkg.sv
hdl/apb_ctrl.sv
hdl/line_decoder.sv
node_map/node_id_mapper.sv
path_count/edge_store.sv
path_count/path_counter.sv
hdl/graph_top.sv
verif/graph_checker.sv
verif/graph_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module graph_tb -f filelist.f -o graph_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/graph_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
